/* common/engine_rw_pkg.sv */
// Shared widths, field sequence-state codes and typedefs for the
// parallel read/write stage. Modules and the interface take these
// through a wildcard import in their headers.

`default_nettype none

package engine_rw_pkg;

  // ------------------------------------------------------------
  // Packet fields
  // ------------------------------------------------------------

  // Width of one data field of a packet
  localparam int FIELD_W = 32;

  typedef logic [FIELD_W-1:0] field_t;

  // Sequence state carried beside every field
  typedef logic [1:0] seq_state_t;

  localparam seq_state_t SEQ_INVALID = 2'd0;
  localparam seq_state_t SEQ_RUNNING = 2'd1;
  localparam seq_state_t SEQ_DONE    = 2'd2;

  // ------------------------------------------------------------
  // Memory request
  // ------------------------------------------------------------

  localparam int ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;

  // Shift amount applied to the request offset
  typedef logic [4:0] gran_t;

  typedef logic [3:0] id_channel_t;
  typedef logic [3:0] id_buffer_t;

  // Cycles from in_valid to out_valid
  localparam int PIPE_DEPTH = 3;

endpackage : engine_rw_pkg

`default_nettype wire

/* common/engine_cfg_if.sv */
// Active configuration of the read/write stage. The control block
// owns it; field select and address generation read their parts.

`timescale 1ns/1ps
`default_nettype none

interface engine_cfg_if
  import engine_rw_pkg::*;
#(
  parameter int NUM_FIELDS = 4
) ();

  // Field selection
  logic [NUM_FIELDS-1:0]                 const_mask;
  logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] ops_mask;
  field_t                                const_value;

  // Request address forming
  addr_t       index_start;
  gran_t       granularity;
  logic        direction;
  id_channel_t id_channel;
  id_buffer_t  id_buffer;

  modport ctrl (
    output const_mask, ops_mask, const_value,
    output index_start, granularity, direction, id_channel, id_buffer
  );

  modport select (
    input const_mask, ops_mask, const_value
  );

  modport addr (
    input index_start, granularity, direction, id_channel, id_buffer
  );

endinterface : engine_cfg_if

`default_nettype wire

/* read_write_engine/engine_rw_control.sv */
// Configuration register and valid pipeline of the read/write stage.
// A new configuration is taken only while no packet is in flight, so
// every packet sees one configuration from entry to exit.

`timescale 1ns/1ps
`default_nettype none

module engine_rw_control
  import engine_rw_pkg::*;
#(
  parameter int NUM_FIELDS = 4
) (
  input  wire logic                                  ap_clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  cfg_load,
  input  wire logic                                  in_valid,
  input  wire logic [NUM_FIELDS-1:0]                 cfg_const_mask,
  input  wire logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] cfg_ops_mask,
  input  wire field_t                                cfg_const_value,
  input  wire addr_t                                 cfg_index_start,
  input  wire gran_t                                 cfg_granularity,
  input  wire logic                                  cfg_direction,
  input  wire id_channel_t                           cfg_id_channel,
  input  wire id_buffer_t                            cfg_id_buffer,
  engine_cfg_if.ctrl                                 cfg,
  output logic                                       out_valid,
  output logic                                       busy
);

  // One bit per pipeline stage, head at bit 0
  logic [PIPE_DEPTH-1:0] valid_sr;
  logic                  load_accept;

  // ------------------------------------------------------------
  // Occupancy
  // ------------------------------------------------------------

  // A packet entering this cycle counts as well
  assign busy        = (|valid_sr) | in_valid;
  assign load_accept = cfg_load & ~busy;

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[PIPE_DEPTH-2:0], in_valid};
    end
  end

  assign out_valid = valid_sr[PIPE_DEPTH-1];

  // ------------------------------------------------------------
  // Configuration register
  // ------------------------------------------------------------

  // A load while busy is simply dropped
  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      cfg.const_mask  <= '0;
      cfg.ops_mask    <= '0;
      cfg.const_value <= '0;
      cfg.index_start <= '0;
      cfg.granularity <= '0;
      cfg.direction   <= 1'b0;
      cfg.id_channel  <= '0;
      cfg.id_buffer   <= '0;
    end else if (load_accept) begin
      cfg.const_mask  <= cfg_const_mask;
      cfg.ops_mask    <= cfg_ops_mask;
      cfg.const_value <= cfg_const_value;
      cfg.index_start <= cfg_index_start;
      cfg.granularity <= cfg_granularity;
      cfg.direction   <= cfg_direction;
      cfg.id_channel  <= cfg_id_channel;
      cfg.id_buffer   <= cfg_id_buffer;
    end
  end

endmodule : engine_rw_control

`default_nettype wire

/* read_write_engine/engine_field_select.sv */
// First datapath stage. Rebuilds the packet field by field from the
// constant, a copy of another input field, or the field itself, and
// registers the result view plus operand field 1 for the address.

`timescale 1ns/1ps
`default_nettype none

module engine_field_select
  import engine_rw_pkg::*;
#(
  parameter int NUM_FIELDS = 4
) (
  input  wire logic                         ap_clk,
  input  wire field_t     [NUM_FIELDS-1:0]  in_fields,
  input  wire seq_state_t [NUM_FIELDS-1:0]  in_states,
  engine_cfg_if.select                      cfg,
  output field_t                            ops_field1,
  output field_t          [NUM_FIELDS-1:0]  org_fields,
  output seq_state_t      [NUM_FIELDS-1:0]  org_states
);

  // Chosen value per field, and whether a constant or copy was chosen
  field_t     [NUM_FIELDS-1:0] pick_field;
  seq_state_t [NUM_FIELDS-1:0] pick_state;
  logic       [NUM_FIELDS-1:0] pick_hit;

  // ------------------------------------------------------------
  // Selection
  // ------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      // Default is pass-through of the same field
      pick_field[i] = in_fields[i];
      pick_state[i] = in_states[i];
      pick_hit[i]   = 1'b0;
      if (cfg.const_mask[i]) begin
        pick_field[i] = cfg.const_value;
        pick_state[i] = SEQ_RUNNING;
        pick_hit[i]   = 1'b1;
      end else begin
        // Ascending scan, so the highest set mask bit wins
        for (int j = 0; j < NUM_FIELDS; j++) begin
          if (cfg.ops_mask[i][j]) begin
            pick_field[i] = in_fields[j];
            pick_state[i] = in_states[j];
            pick_hit[i]   = 1'b1;
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Stage 1 registers
  // ------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    // Operand view is zero for an unmasked field
    ops_field1 <= pick_hit[1] ? pick_field[1] : '0;
    org_fields <= pick_field;
    org_states <= pick_state;
  end

endmodule : engine_field_select

`default_nettype wire

/* read_write_engine/engine_address_gen.sv */
// Second and third datapath stages. Forms the shifted request offset
// from index_start and operand field 1, keeps the result fields in
// step, then registers both into the output stage.

`timescale 1ns/1ps
`default_nettype none

module engine_address_gen
  import engine_rw_pkg::*;
#(
  parameter int NUM_FIELDS = 4
) (
  input  wire logic                         ap_clk,
  input  wire field_t                       ops_field1,
  input  wire field_t     [NUM_FIELDS-1:0]  org_fields,
  input  wire seq_state_t [NUM_FIELDS-1:0]  org_states,
  engine_cfg_if.addr                        cfg,
  output addr_t                             req_offset,
  output gran_t                             req_shift_amount,
  output logic                              req_direction,
  output id_channel_t                       req_id_channel,
  output id_buffer_t                        req_id_buffer,
  output field_t          [NUM_FIELDS-1:0]  out_fields,
  output seq_state_t      [NUM_FIELDS-1:0]  out_states
);

  addr_t                       base_sum;
  addr_t                       offset_q;
  gran_t                       shift_q;
  logic                        dir_q;
  id_channel_t                 chan_q;
  id_buffer_t                  buf_q;
  field_t     [NUM_FIELDS-1:0] fields_q;
  seq_state_t [NUM_FIELDS-1:0] states_q;

  // Sum wraps at ADDR_W bits
  assign base_sum = cfg.index_start + ops_field1;

  // Stage 2: offset and request fields, result delayed beside them
  always_ff @(posedge ap_clk) begin
    if (cfg.direction) begin
      offset_q <= base_sum << cfg.granularity;
    end else begin
      offset_q <= base_sum >> cfg.granularity;
    end
    shift_q  <= cfg.granularity;
    dir_q    <= cfg.direction;
    chan_q   <= cfg.id_channel;
    buf_q    <= cfg.id_buffer;
    fields_q <= org_fields;
    states_q <= org_states;
  end

  // Stage 3: output registers
  always_ff @(posedge ap_clk) begin
    req_offset       <= offset_q;
    req_shift_amount <= shift_q;
    req_direction    <= dir_q;
    req_id_channel   <= chan_q;
    req_id_buffer    <= buf_q;
    out_fields       <= fields_q;
    out_states       <= states_q;
  end

endmodule : engine_address_gen

`default_nettype wire

/* source/engine_rw_top.sv */
// Top level of the parallel read/write stage. Plain ports only; the
// configuration travels to the datapath over one engine_cfg_if.
// Outputs appear exactly PIPE_DEPTH cycles after in_valid.

`timescale 1ns/1ps
`default_nettype none

module engine_rw_top
  import engine_rw_pkg::*;
#(
  parameter int NUM_FIELDS = 4
) (
  input  wire logic                                  ap_clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  cfg_load,
  input  wire logic [NUM_FIELDS-1:0]                 cfg_const_mask,
  input  wire logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] cfg_ops_mask,
  input  wire field_t                                cfg_const_value,
  input  wire addr_t                                 cfg_index_start,
  input  wire gran_t                                 cfg_granularity,
  input  wire logic                                  cfg_direction,
  input  wire id_channel_t                           cfg_id_channel,
  input  wire id_buffer_t                            cfg_id_buffer,
  input  wire logic                                  in_valid,
  input  wire field_t     [NUM_FIELDS-1:0]           in_fields,
  input  wire seq_state_t [NUM_FIELDS-1:0]           in_states,
  output logic                                       busy,
  output logic                                       out_valid,
  output field_t          [NUM_FIELDS-1:0]           out_fields,
  output seq_state_t      [NUM_FIELDS-1:0]           out_states,
  output logic                                       req_valid,
  output addr_t                                      req_offset,
  output gran_t                                      req_shift_amount,
  output logic                                       req_direction,
  output id_channel_t                                req_id_channel,
  output id_buffer_t                                 req_id_buffer
);

  logic                        pipe_valid;
  field_t                      ops_field1;
  field_t     [NUM_FIELDS-1:0] org_fields;
  seq_state_t [NUM_FIELDS-1:0] org_states;

  engine_cfg_if #(.NUM_FIELDS(NUM_FIELDS)) cfg_bus ();

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  engine_rw_control #(.NUM_FIELDS(NUM_FIELDS)) u_control (
    .ap_clk          (ap_clk),
    .rst_n           (rst_n),
    .cfg_load        (cfg_load),
    .in_valid        (in_valid),
    .cfg_const_mask  (cfg_const_mask),
    .cfg_ops_mask    (cfg_ops_mask),
    .cfg_const_value (cfg_const_value),
    .cfg_index_start (cfg_index_start),
    .cfg_granularity (cfg_granularity),
    .cfg_direction   (cfg_direction),
    .cfg_id_channel  (cfg_id_channel),
    .cfg_id_buffer   (cfg_id_buffer),
    .cfg             (cfg_bus.ctrl),
    .out_valid       (pipe_valid),
    .busy            (busy)
  );

  // Result and request leave together
  assign out_valid = pipe_valid;
  assign req_valid = pipe_valid;

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------

  engine_field_select #(.NUM_FIELDS(NUM_FIELDS)) u_field_select (
    .ap_clk     (ap_clk),
    .in_fields  (in_fields),
    .in_states  (in_states),
    .cfg        (cfg_bus.select),
    .ops_field1 (ops_field1),
    .org_fields (org_fields),
    .org_states (org_states)
  );

  engine_address_gen #(.NUM_FIELDS(NUM_FIELDS)) u_address_gen (
    .ap_clk           (ap_clk),
    .ops_field1       (ops_field1),
    .org_fields       (org_fields),
    .org_states       (org_states),
    .cfg              (cfg_bus.addr),
    .req_offset       (req_offset),
    .req_shift_amount (req_shift_amount),
    .req_direction    (req_direction),
    .req_id_channel   (req_id_channel),
    .req_id_buffer    (req_id_buffer),
    .out_fields       (out_fields),
    .out_states       (out_states)
  );

endmodule : engine_rw_top

`default_nettype wire

/* tb/engine_rw_assert.sv */
// Concurrent checks on the control block of the read/write stage.
// Bound into every engine_rw_control instance at the end of this file.

`timescale 1ns/1ps
`default_nettype none

module engine_rw_assert
  import engine_rw_pkg::*;
#(
  parameter int  NUM_FIELDS = 4,
  localparam int CFG_W = NUM_FIELDS + NUM_FIELDS * NUM_FIELDS + FIELD_W + ADDR_W
                       + $bits(gran_t) + 1 + $bits(id_channel_t) + $bits(id_buffer_t)
) (
  input wire logic             ap_clk,
  input wire logic             rst_n,
  input wire logic             in_valid,
  input wire logic             out_valid,
  input wire logic             busy,
  input wire logic [CFG_W-1:0] cfg_word
);

  // Each packet leaves exactly PIPE_DEPTH cycles after it enters
  valid_latency: assert property (
    @(posedge ap_clk) disable iff (!rst_n) out_valid == $past(in_valid, PIPE_DEPTH)
  ) else $error("out_valid is not in_valid delayed by %0d cycles", PIPE_DEPTH);

  idle_after_reset: assert property (
    @(posedge ap_clk) !rst_n |=> !busy
  ) else $error("busy is high right after reset");

  // No load can land while a packet is in flight
  cfg_held_while_busy: assert property (
    @(posedge ap_clk) disable iff (!rst_n) busy |=> $stable(cfg_word)
  ) else $error("configuration changed while the pipeline was busy");

endmodule : engine_rw_assert

bind engine_rw_control engine_rw_assert #(.NUM_FIELDS(NUM_FIELDS)) u_assert (
  .ap_clk    (ap_clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .busy      (busy),
  .cfg_word  ({cfg.const_mask, cfg.ops_mask, cfg.const_value, cfg.index_start,
               cfg.granularity, cfg.direction, cfg.id_channel, cfg.id_buffer})
);

`default_nettype wire

/* tb/engine_rw_tb.sv */
// Testbench for the parallel read/write stage. Loads random
// configurations, streams random packets with and without gaps, and
// checks every output against a model of the selection and address rules.

`timescale 1ns/1ps
`default_nettype none

module engine_rw_tb
  import engine_rw_pkg::*;
();

  localparam int NUM_FIELDS     = 4;
  localparam int RESET_CYCLES   = 5;
  localparam int PKT            = 24;
  localparam int MAX_GAP        = 2;
  localparam int NUM_STREAMS    = 11;
  localparam int NUM_LOADS      = 10;
  localparam int PLANNED_CYCLES = RESET_CYCLES + NUM_LOADS * 4
                                + NUM_STREAMS * (PKT * (MAX_GAP + 1) + PIPE_DEPTH + 4);
  localparam int CYCLE_LIMIT    = 2 * PLANNED_CYCLES;

  typedef field_t     [NUM_FIELDS-1:0] fields_t;
  typedef seq_state_t [NUM_FIELDS-1:0] states_t;

  // One expected output, with the cycle it must appear in
  typedef struct packed {
    fields_t     fields;
    states_t     states;
    addr_t       offset;
    gran_t       shift;
    logic        dir;
    id_channel_t chan;
    id_buffer_t  bufid;
    logic [31:0] due;
  } expect_t;

  logic                                  ap_clk;
  logic                                  rst_n;
  logic                                  cfg_load;
  logic [NUM_FIELDS-1:0]                 cfg_const_mask;
  logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] cfg_ops_mask;
  field_t                                cfg_const_value;
  addr_t                                 cfg_index_start;
  gran_t                                 cfg_granularity;
  logic                                  cfg_direction;
  id_channel_t                           cfg_id_channel;
  id_buffer_t                            cfg_id_buffer;
  logic                                  in_valid;
  fields_t                               in_fields;
  states_t                               in_states;
  logic                                  busy;
  logic                                  out_valid;
  fields_t                               out_fields;
  states_t                               out_states;
  logic                                  req_valid;
  addr_t                                 req_offset;
  gran_t                                 req_shift_amount;
  logic                                  req_direction;
  id_channel_t                           req_id_channel;
  id_buffer_t                            req_id_buffer;

  integer  seed        = 82017;
  int      cycle       = 0;
  int      checked     = 0;
  expect_t exp_q[$];

  // Configuration the DUT is expected to hold
  logic [NUM_FIELDS-1:0]                 m_const_mask;
  logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] m_ops_mask;
  field_t                                m_const_value;
  addr_t                                 m_index_start;
  gran_t                                 m_granularity;
  logic                                  m_direction;
  id_channel_t                           m_id_channel;
  id_buffer_t                            m_id_buffer;

  engine_rw_top #(.NUM_FIELDS(NUM_FIELDS)) dut (.*);

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  // ------------------------------------------------------------
  // Checking
  // ------------------------------------------------------------

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "run stopped at cycle %0d", cycle);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_output(input expect_t e);
    for (int i = 0; i < NUM_FIELDS; i++) begin
      compare_value($sformatf("out_fields[%0d]", i), out_fields[i], e.fields[i]);
      compare_value($sformatf("out_states[%0d]", i), 32'(out_states[i]), 32'(e.states[i]));
    end
    compare_value("req_offset", req_offset, e.offset);
    compare_value("req_shift_amount", 32'(req_shift_amount), 32'(e.shift));
    compare_value("req_direction", 32'(req_direction), 32'(e.dir));
    compare_value("req_id_channel", 32'(req_id_channel), 32'(e.chan));
    compare_value("req_id_buffer", 32'(req_id_buffer), 32'(e.bufid));
    checked++;
  endtask

  // Model of the selection and address rules
  function automatic expect_t predict(input fields_t f, input states_t s);
    expect_t e;
    field_t  op1;
    addr_t   sum;
    logic    hit;
    op1 = '0;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      hit = 1'b0;
      e.fields[i] = f[i];
      e.states[i] = s[i];
      if (m_const_mask[i]) begin
        e.fields[i] = m_const_value;
        e.states[i] = SEQ_RUNNING;
        hit = 1'b1;
      end
      // Search from the top so the highest set bit picks the source
      for (int j = NUM_FIELDS - 1; j >= 0; j--) begin
        if (!hit && m_ops_mask[i][j]) begin
          e.fields[i] = f[j];
          e.states[i] = s[j];
          hit = 1'b1;
        end
      end
      if (i == 1 && hit) op1 = e.fields[i];
    end
    sum = m_index_start + op1;
    e.offset = m_direction ? (sum << m_granularity) : (sum >> m_granularity);
    e.shift  = m_granularity;
    e.dir    = m_direction;
    e.chan   = m_id_channel;
    e.bufid  = m_id_buffer;
    e.due    = 32'(cycle + PIPE_DEPTH);
    return e;
  endfunction

  // Every queued packet is either entering or inside the pipeline
  always @(negedge ap_clk) begin
    logic due_now;
    if (rst_n) begin
      due_now = exp_q.size() != 0 && exp_q[0].due == 32'(cycle);
      compare_value("busy", 32'(busy), 32'(exp_q.size() != 0));
      compare_value("req_valid", 32'(req_valid), 32'(due_now));
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("out_valid was high with no packet in flight");
          stop_run();
        end else if (exp_q[0].due != 32'(cycle)) begin
          $display("output came in cycle %0d but was due in cycle %0d", cycle, exp_q[0].due);
          stop_run();
        end else begin
          check_output(exp_q.pop_front());
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= 32'(cycle)) begin
        $display("no output for the packet due in cycle %0d", exp_q[0].due);
        stop_run();
      end
    end
  end

  always @(posedge ap_clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_run();
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  // Modes: 0 random, 1 constants, 2 copies, 3 no masks, 4 left, 5 right
  task automatic pick_config(input int mode);
    logic [31:0] r;
    r = $random(seed);
    cfg_const_value = $random(seed);
    cfg_index_start = $random(seed);
    cfg_granularity = r[4:0];
    cfg_direction   = r[5];
    cfg_id_channel  = r[11:8];
    cfg_id_buffer   = r[15:12];
    r = $random(seed);
    cfg_const_mask = r[3:0] & r[7:4];
    cfg_ops_mask   = r[31:16];
    if (mode == 1) begin
      cfg_const_mask = r[3:0] | 4'b0010;
    end else if (mode == 2) begin
      // At least two source bits on every field
      cfg_const_mask = '0;
      cfg_ops_mask   = r[31:16] | 16'h9C63;
    end else if (mode == 3) begin
      cfg_const_mask = '0;
      cfg_ops_mask   = '0;
    end else if (mode >= 4) begin
      cfg_direction = (mode == 4);
    end
  endtask

  // Mode below zero keeps the configuration ports as they are
  task automatic drive_cycle(input logic send, input logic load, input logic take,
                             input int mode);
    logic [31:0] r;
    @(posedge ap_clk);
    #2;
    if (mode >= 0) pick_config(mode);
    for (int i = 0; i < NUM_FIELDS; i++) begin
      r = $random(seed);
      in_fields[i] = $random(seed);
      in_states[i] = r[1:0];
    end
    in_valid = send;
    cfg_load = load;
    if (take) begin
      m_const_mask  = cfg_const_mask;
      m_ops_mask    = cfg_ops_mask;
      m_const_value = cfg_const_value;
      m_index_start = cfg_index_start;
      m_granularity = cfg_granularity;
      m_direction   = cfg_direction;
      m_id_channel  = cfg_id_channel;
      m_id_buffer   = cfg_id_buffer;
    end
    if (send) exp_q.push_back(predict(in_fields, in_states));
  endtask

  task automatic wait_idle();
    @(negedge ap_clk);
    while (busy) @(negedge ap_clk);
  endtask

  task automatic load_config(input int mode);
    wait_idle();
    drive_cycle(1'b0, 1'b1, 1'b1, mode);
    drive_cycle(1'b0, 1'b0, 1'b0, -1);
  endtask

  task automatic stream(input int count, input int max_gap);
    int gap;
    for (int k = 0; k < count; k++) begin
      drive_cycle(1'b1, 1'b0, 1'b0, -1);
      gap = int'({$random(seed)} % (max_gap + 1));
      repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, -1);
    end
    drive_cycle(1'b0, 1'b0, 1'b0, -1);
  endtask

  initial begin
    rst_n           = 1'b0;
    cfg_load        = 1'b0;
    cfg_const_mask  = '0;
    cfg_ops_mask    = '0;
    cfg_const_value = '0;
    cfg_index_start = '0;
    cfg_granularity = '0;
    cfg_direction   = 1'b0;
    cfg_id_channel  = '0;
    cfg_id_buffer   = '0;
    in_valid        = 1'b0;
    in_fields       = '0;
    in_states       = '0;
    m_const_mask    = '0;
    m_ops_mask      = '0;
    m_const_value   = '0;
    m_index_start   = '0;
    m_granularity   = '0;
    m_direction     = 1'b0;
    m_id_channel    = '0;
    m_id_buffer     = '0;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #2;
    rst_n = 1'b1;

    // Constant, copy and pass-through selection
    for (int mode = 1; mode <= 3; mode++) begin
      load_config(mode);
      stream(PKT, 1);
    end
    // Address forming in both directions
    for (int k = 0; k < 4; k++) begin
      load_config(4 + k % 2);
      stream(PKT, MAX_GAP);
    end
    // Back-to-back, then with gaps
    load_config(0);
    stream(PKT, 0);
    stream(PKT, MAX_GAP);
    // Loads issued while busy are dropped, a later idle load is taken
    load_config(0);
    for (int k = 0; k < PKT; k++) begin
      drive_cycle(1'b1, k % 4 == 0, 1'b0, (k % 4 == 0) ? 1 : -1);
    end
    drive_cycle(1'b0, 1'b1, 1'b0, -1);
    drive_cycle(1'b0, 1'b0, 1'b0, -1);
    load_config(-1);
    stream(PKT, 1);

    wait_idle();
    if (exp_q.size() == 0 && checked > 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("run ended with %0d packets in flight and %0d checked", exp_q.size(), checked);
      stop_run();
    end
  end

endmodule : engine_rw_tb

`default_nettype wire

/* sim.f */
common/engine_rw_pkg.sv
common/engine_cfg_if.sv
read_write_engine/engine_rw_control.sv
read_write_engine/engine_field_select.sv
read_write_engine/engine_address_gen.sv
source/engine_rw_top.sv
tb/engine_rw_assert.sv
tb/engine_rw_tb.sv

/* Makefile */
# Verilator build and run of the read/write stage testbench

VERILATOR  ?= verilator
TOP        := engine_rw_tb
RTL_TOP    := engine_rw_top
FILELIST   := sim.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BIN        := obj_dir/V$(TOP)
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
